// File: verilog.f
+incdir+include
logic/fpFormatPkg.sv
logic/addPipePkg.sv
logic/operandSwap.sv
logic/alignAdd.sv
logic/normalizer.sv
logic/roundPack.sv
logic/fpAddSub.sv
dv/fpAddSubTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fpAddSub testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert -f verilog.f \
	--top-module fpAddSubTb -o fpAddSubSim; then
	echo "Build failed"
	exit 1
fi

if ! ./obj_dir/fpAddSubSim > "$logFile" 2>&1; then
	cat "$logFile"
	echo "Simulation returned a failing status"
	exit 1
fi

cat "$logFile"

if grep -q "Finished with no errors" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1

// File: include/fpAddSubModel.svh
`ifndef FP_ADD_SUB_MODEL_SVH
`define FP_ADD_SUB_MODEL_SVH

// Expected output word and flags for one operation
typedef struct packed {
	fpFormatPkg::fp16Word   result;
	fpFormatPkg::addFlags_t flags;
} refResult_t;

////////////////////////////////////////////////////////////
// Reference, exact integer sum then a single rounding
////////////////////////////////////////////////////////////
function automatic refResult_t fpAddSubRef(
	input fpFormatPkg::fp16Word a,
	input fpFormatPkg::fp16Word b,
	input logic                 op
);
	refResult_t      outcome;
	logic            bSign;
	logic            aNaN;
	logic            bNaN;
	logic            aInf;
	logic            bInf;
	longint          aVal;	// Signed, in units of 2**-24
	longint          bVal;
	longint          total;
	longint unsigned mag;
	longint unsigned kept;
	longint unsigned rem;
	longint unsigned half;
	int              msb;
	int              shift;
	int              biasedExp;
	logic            inexact;

	outcome = '0;
	bSign   = b.fields.sign ^ op;	// Effective sign of b
	aNaN    = (&a.fields.exponent) && (|a.fields.fraction);
	bNaN    = (&b.fields.exponent) && (|b.fields.fraction);
	aInf    = (&a.fields.exponent) && !(|a.fields.fraction);
	bInf    = (&b.fields.exponent) && !(|b.fields.fraction);

	if (aNaN || bNaN || (aInf && bInf && (a.fields.sign != bSign))) begin
		outcome.result        = fpFormatPkg::qNaN;
		outcome.flags.invalid = 1'b1;
		return outcome;
	end
	if (aInf) begin
		outcome.result = a;
		return outcome;
	end
	if (bInf) begin
		outcome.result = {bSign, b.raw[14:0]};
		return outcome;
	end

	// Zero exponent reads as zero, subnormals included
	aVal = 0;
	bVal = 0;
	if (a.fields.exponent != 0)
		aVal = longint'({1'b1, a.fields.fraction}) << (a.fields.exponent - 1);
	if (b.fields.exponent != 0)
		bVal = longint'({1'b1, b.fields.fraction}) << (b.fields.exponent - 1);
	if (a.fields.sign)
		aVal = -aVal;
	if (bSign)
		bVal = -bVal;
	total = aVal + bVal;

	if (total == 0) begin
		outcome.result.fields.sign = a.fields.sign & bSign;	// -0 only from two negatives
		return outcome;
	end
	outcome.result.fields.sign = (total < 0);
	mag = (total < 0) ? -total : total;
	msb = 0;
	for (int i = 0; i < 64; i++) begin
		if (mag[i])
			msb = i;
	end

	// Leading one at bit 24 is 1.0, biased 15
	biasedExp = msb - fpFormatPkg::fracWidth + 1;
	inexact   = 1'b0;
	if (msb > fpFormatPkg::fracWidth) begin
		shift   = msb - fpFormatPkg::fracWidth;
		kept    = mag >> shift;
		rem     = mag & ((64'd1 << shift) - 1);
		half    = 64'd1 << (shift - 1);
		inexact = (rem != 0);
		if (rem > half || (rem == half && kept[0]))
			kept = kept + 1;
		if (kept[fpFormatPkg::fracWidth+1]) begin
			kept      = kept >> 1;	// Rounding carried into the exponent
			biasedExp = biasedExp + 1;
		end
	end else
		kept = mag << (fpFormatPkg::fracWidth - msb);

	// Largest finite biased exponent is twice the bias
	if (biasedExp > 2 * fpFormatPkg::expBias) begin
		outcome.result.fields.exponent = '1;
		outcome.flags.overflow         = 1'b1;
		outcome.flags.inexact          = 1'b1;
	end else if (biasedExp <= 0) begin
		outcome.flags.underflow = 1'b1;
		outcome.flags.inexact   = 1'b1;
	end else begin
		outcome.result.fields.exponent = biasedExp[4:0];
		outcome.result.fields.fraction = kept[fpFormatPkg::fracWidth-1:0];
		outcome.flags.inexact          = inexact;
	end
	return outcome;
endfunction

`endif

// File: dv/fpAddSubTb.sv
module fpAddSubTb;
	timeunit 1ns;
	timeprecision 100ps;

	import fpFormatPkg::*;

	`include "fpAddSubModel.svh"

	localparam int clkPeriod     = 4;
	localparam int resetCycles   = 4;
	localparam int latency       = 5;	// Register stages including the output register
	localparam int directedCount = 24;
	localparam int randomCount   = 2000;
	localparam int vectorCount   = directedCount + randomCount;

	logic      clk = 1'b0;	// Starts low so there is no edge at time zero
	logic      rst;
	fp16Word   a;
	fp16Word   b;
	logic      op;
	fp16Word   result;
	addFlags_t flags;

	string      testName;	// Name of the pair now on the inputs
	integer     seed;
	int         errorCount;
	refResult_t expLine [latency];	// Expected values waiting for their edge
	string      lineName [latency];

	fpAddSub uut (
		.clk    (clk),
		.rst    (rst),
		.a      (a),
		.b      (b),
		.op     (op),
		.result (result),
		.flags  (flags)
	);

	initial begin
		forever #(clkPeriod / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic checkResult(input string name, input fp16Word expected, input fp16Word actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s: result expected %h, got %h", name, expected.raw, actual.raw);
			$display("Finished with errors");
			$fatal(1, "Result word mismatch");
		end
	endtask

	task automatic checkFlags(input string name, input addFlags_t expected, input addFlags_t actual);
		if (actual !== expected) begin
			errorCount++;
			// Flag order is overflow, underflow, invalid, inexact
			$display("[FAIL] %s: flags expected %b, got %b", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Flag mismatch");
		end
	endtask

	// One pair per rising edge
	task automatic driveOp(input string name, input logic [15:0] aRaw, input logic [15:0] bRaw,
		input logic opIn);
		@(posedge clk);
		a        <= aRaw;
		b        <= bRaw;
		op       <= opIn;
		testName = name;
	endtask

	////////////////////////////////////////////////////////////
	// Compare process reads outputs at the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		checkResult(lineName[latency-1], expLine[latency-1].result, result);
		checkFlags(lineName[latency-1], expLine[latency-1].flags, flags);
		for (int i = latency - 1; i > 0; i--) begin
			expLine[i]  = expLine[i-1];
			lineName[i] = lineName[i-1];
		end
		// Next edge takes this pair or clears the pipeline under reset
		lineName[0] = rst ? "reset" : testName;
		expLine[0]  = rst ? refResult_t'(0) : fpAddSubRef(a, b, op);
	end

	// Watchdog sized from the vector count
	initial begin
		#((vectorCount + 20) * clkPeriod);
		$display("Timeout: the run did not reach its end in time");
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] rndA;
		logic [31:0] rndB;
		logic [15:0] bRaw;

		seed       = 32'h9d38;
		errorCount = 0;
		// Output reads zero from the first reset edge until real pairs arrive
		for (int i = 0; i < latency; i++) begin
			expLine[i]  = '0;
			lineName[i] = "reset";
		end
		rst      = 1'b1;
		a        = 16'h3C00;	// Nonzero during reset while the output still reads zero
		b        = 16'h4000;
		op       = 1'b0;
		testName = "reset";
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;

		// Exact results
		driveOp("one plus one", 16'h3C00, 16'h3C00, 1'b0);
		driveOp("two minus one", 16'h4000, 16'h3C00, 1'b1);
		driveOp("x minus x", 16'h4248, 16'h4248, 1'b1);
		driveOp("neg zero plus neg zero", 16'h8000, 16'h8000, 1'b0);
		driveOp("neg two plus one", 16'hC000, 16'h3C00, 1'b0);
		driveOp("one minus two", 16'h3C00, 16'h4000, 1'b1);
		driveOp("zero minus neg zero", 16'h0000, 16'h8000, 1'b1);
		driveOp("subnormal as zero", 16'h0001, 16'h3C00, 1'b0);
		// Rounding
		driveOp("tie down to even", 16'h3C00, 16'h1000, 1'b0);
		driveOp("tie up to even", 16'h3C01, 16'h1000, 1'b0);
		driveOp("round carry to exponent", 16'h3BFF, 16'h0C00, 1'b0);
		driveOp("sticky only", 16'h3C00, 16'h0400, 1'b0);
		// Range limits
		driveOp("overflow positive", 16'h7BFF, 16'h7BFF, 1'b0);
		driveOp("overflow negative", 16'hFBFF, 16'h7BFF, 1'b1);
		driveOp("overflow by rounding", 16'h7BFF, 16'h4C00, 1'b0);
		driveOp("underflow positive", 16'h0401, 16'h0400, 1'b1);
		driveOp("underflow negative", 16'h8401, 16'h0400, 1'b0);
		// Specials
		driveOp("quiet nan input", 16'h7E00, 16'h3C00, 1'b0);
		driveOp("signaling nan input", 16'h3C00, 16'h7C01, 1'b0);
		driveOp("inf minus inf", 16'h7C00, 16'h7C00, 1'b1);
		driveOp("inf plus neg inf", 16'h7C00, 16'hFC00, 1'b0);
		driveOp("inf plus finite", 16'h7C00, 16'h3C00, 1'b0);
		driveOp("finite minus inf", 16'h3C00, 16'h7C00, 1'b1);
		driveOp("neg inf plus neg inf", 16'hFC00, 16'hFC00, 1'b0);

		// Back to back pairs with every fourth b close to a for cancellation
		for (int i = 0; i < randomCount; i++) begin
			rndA = $random(seed);
			rndB = $random(seed);
			bRaw = (i % 4 == 3) ? (rndA[15:0] ^ (rndB[15:0] & 16'h803F)) : rndB[15:0];
			driveOp($sformatf("random %0d", i), rndA[15:0], bRaw, rndB[16]);
		end

		repeat (latency + 1) @(posedge clk);	// Drain the pipeline
		if (errorCount == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "Mismatches found");
		end
	end

endmodule

// File: logic/fpAddSub.sv
module fpAddSub (
	input  logic                   clk,
	input  logic                   rst,
	input  fpFormatPkg::fp16Word   a,
	input  fpFormatPkg::fp16Word   b,
	input  logic                   op,		// 0 add, 1 subtract
	output fpFormatPkg::fp16Word   result,
	output fpFormatPkg::addFlags_t flags
);
	import addPipePkg::*;

	swapStage_t swapReg;	// Stage 1 output
	sumStage_t  sumReg;		// Stage 2 output
	normStage_t normReg;	// Stage 3 output

	// Classify, handle specials, order by magnitude
	operandSwap stage1Swap (
		.clk     (clk),
		.rst     (rst),
		.a       (a),
		.b       (b),
		.op      (op),
		.swapOut (swapReg)
	);

	// Align smaller operand, add or subtract
	alignAdd stage2Align (
		.clk    (clk),
		.rst    (rst),
		.swapIn (swapReg),
		.sumOut (sumReg)
	);

	normalizer stage3Norm (
		.clk     (clk),
		.rst     (rst),
		.sumIn   (sumReg),
		.normOut (normReg)
	);

	// Round, then range check and pack, two registers
	roundPack stage4Round (
		.clk    (clk),
		.rst    (rst),
		.normIn (normReg),
		.result (result),
		.flags  (flags)
	);

endmodule

// File: logic/roundPack.sv
module roundPack (
	input  logic                   clk,
	input  logic                   rst,
	input  addPipePkg::normStage_t normIn,
	output fpFormatPkg::fp16Word   result,
	output fpFormatPkg::addFlags_t flags
);
	import fpFormatPkg::*;
	import addPipePkg::*;

	localparam int expMax = (1 << expWidth) - 1;	// Exponent of infinity

	// Rounded value between stage 4 and stage 5
	typedef struct packed {
		logic                       sign;
		logic signed [expWidth+1:0] exponent;
		logic [fracWidth-1:0]       fraction;
		logic                       inexact;	// Guard or sticky was set
		logic                       nonZero;	// Real nonzero value with its hidden bit
		specialInfo_t               special;
	} roundStage_t;

	logic                 roundUp;
	logic [fracWidth+1:0] sigRounded;	// Top bit is the rounding carry
	roundStage_t          roundNext;
	roundStage_t          roundReg;
	fp16Word              resultNext;
	addFlags_t            flagsNext;

	////////////////////////////////////////////////////////////
	// Stage 4 rounds to nearest even
	////////////////////////////////////////////////////////////
	assign roundUp    = normIn.guard & (normIn.sticky | normIn.sig[0]);	// Tie goes to even lsb
	assign sigRounded = {1'b0, normIn.sig} + {{(fracWidth + 1){1'b0}}, roundUp};

	always_comb begin
		roundNext.sign    = normIn.sign;
		roundNext.nonZero = normIn.sig[fracWidth] & ~normIn.zero;	// Cleared stage has no hidden bit
		roundNext.special = normIn.special;
		roundNext.inexact = normIn.guard | normIn.sticky;
		if (sigRounded[fracWidth+1]) begin
			roundNext.exponent = $signed(normIn.exponent) + 7'sd1;	// 1.111.. rolled over
			roundNext.fraction = sigRounded[fracWidth:1];
		end else begin
			roundNext.exponent = normIn.exponent;
			roundNext.fraction = sigRounded[fracWidth-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 5 checks the range and packs
	////////////////////////////////////////////////////////////
	always_comb begin
		flagsNext                  = '0;
		resultNext.fields.sign     = roundReg.sign;
		resultNext.fields.exponent = roundReg.exponent[expWidth-1:0];
		resultNext.fields.fraction = roundReg.fraction;
		if (roundReg.special.isSpecial) begin
			resultNext        = roundReg.special.word;	// NaN or infinity wins
			flagsNext.invalid = roundReg.special.invalid;
		end else if (!roundReg.nonZero) begin
			resultNext.fields.exponent = '0;
			resultNext.fields.fraction = '0;
		end else if ($signed(roundReg.exponent) >= expMax) begin
			resultNext.fields.exponent = '1;	// Signed infinity
			resultNext.fields.fraction = '0;
			flagsNext.overflow         = 1'b1;
			flagsNext.inexact          = 1'b1;
		end else if ($signed(roundReg.exponent) <= 0) begin
			resultNext.fields.exponent = '0;	// Flushed to signed zero
			resultNext.fields.fraction = '0;
			flagsNext.underflow        = 1'b1;
			flagsNext.inexact          = 1'b1;
		end else
			flagsNext.inexact = roundReg.inexact;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			roundReg <= '0;
			result   <= '0;
			flags    <= '0;
		end else begin
			roundReg <= roundNext;
			result   <= resultNext;
			flags    <= flagsNext;
		end
	end

	// Overflow leaves an infinity and never comes with underflow
	assert property (@(posedge clk) disable iff (rst)
		flags.overflow |-> !flags.underflow && (&result.fields.exponent));

endmodule

// File: logic/normalizer.sv
module normalizer (
	input  logic                   clk,
	input  logic                   rst,
	input  addPipePkg::sumStage_t  sumIn,
	output addPipePkg::normStage_t normOut
);
	import fpFormatPkg::*;
	import addPipePkg::*;

	localparam int sumWidth = fracWidth + 5;	// Carry, 11 bits, G, R, S

	logic                carry;
	logic [sumWidth-2:0] body;		// Sum below the carry
	logic [3:0]          lz;		// Leading zeros of body, 14 when empty
	logic [sumWidth-2:0] shifted;
	normStage_t          normNext;

	assign carry = sumIn.sum[sumWidth-1];
	assign body  = sumIn.sum[sumWidth-2:0];

	// Leading zero count
	always_comb begin
		lz = 4'd14;
		for (int i = 0; i < sumWidth - 1; i++) begin
			if (body[i])
				lz = 4'(sumWidth - 2 - i);	// Highest set bit wins, loop runs upward
		end
	end

	assign shifted = body << lz;	// Hidden bit back to the top

	always_comb begin
		normNext.sign    = sumIn.sign;	// Exact-zero sign already settled in stage 1
		normNext.zero    = ~|sumIn.sum;
		normNext.special = sumIn.special;
		if (carry) begin
			// One place right, bottom two bits fold into sticky
			normNext.exponent = $signed({2'b00, sumIn.exponent}) + 7'sd1;
			normNext.sig      = sumIn.sum[sumWidth-1:4];
			normNext.guard    = sumIn.sum[3];
			normNext.sticky   = |sumIn.sum[2:0];
		end else begin
			// Signed so an exponent under 1 stays visible for underflow
			normNext.exponent = $signed({2'b00, sumIn.exponent}) - $signed({3'b000, lz});
			normNext.sig      = shifted[sumWidth-2:3];
			normNext.guard    = shifted[2];
			normNext.sticky   = |shifted[1:0];	// Round and sticky merged
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			normOut <= '0;
		else
			normOut <= normNext;
	end

endmodule

// File: logic/alignAdd.sv
module alignAdd (
	input  logic                   clk,
	input  logic                   rst,
	input  addPipePkg::swapStage_t swapIn,
	output addPipePkg::sumStage_t  sumOut
);
	import fpFormatPkg::*;
	import addPipePkg::*;

	localparam int alignWidth = fracWidth + 4;	// 11 significant plus guard, round, sticky
	localparam int maxShift   = 15;			// Saturated shift from stage 1

	logic [alignWidth+maxShift-1:0] shiftWide;	// Lost bits land in the low part
	logic                           lostBits;
	logic [alignWidth-1:0]          bigAligned;
	logic [alignWidth-1:0]          smallAligned;
	logic [alignWidth:0]            rawSum;		// One extra bit for the carry
	sumStage_t                      sumNext;

	////////////////////////////////////////////////////////////
	// Alignment
	////////////////////////////////////////////////////////////
	assign shiftWide = {swapIn.smallSig, 3'b000, {maxShift{1'b0}}} >> swapIn.expDiff;
	assign lostBits  = |shiftWide[maxShift-1:0];	// Everything past the sticky slot

	// Sticky slot keeps its own bit ORed with all lost bits
	assign smallAligned = {shiftWide[alignWidth+maxShift-1:maxShift+1],
		shiftWide[maxShift] | lostBits};
	assign bigAligned = {swapIn.bigSig, 3'b000};	// Larger operand never shifts

	////////////////////////////////////////////////////////////
	// Effective add or subtract
	////////////////////////////////////////////////////////////
	assign rawSum = swapIn.effSub ? {1'b0, bigAligned} - {1'b0, smallAligned}
		: {1'b0, bigAligned} + {1'b0, smallAligned};

	always_comb begin
		sumNext.sign     = swapIn.sign;
		sumNext.exponent = swapIn.bigExp;	// Common exponent before normalizing
		sumNext.sum      = rawSum;
		sumNext.special  = swapIn.special;
	end

	always_ff @(posedge clk) begin
		if (rst)
			sumOut <= '0;
		else
			sumOut <= sumNext;
	end

	// Ordering in stage 1 means a subtract never borrows past the top
	assert property (@(posedge clk) disable iff (rst)
		$past(swapIn.effSub) |-> !sumOut.sum[alignWidth]);

endmodule

// File: logic/operandSwap.sv
module operandSwap (
	input  logic                   clk,
	input  logic                   rst,
	input  fpFormatPkg::fp16Word   a,
	input  fpFormatPkg::fp16Word   b,
	input  logic                   op,
	output addPipePkg::swapStage_t swapOut
);
	import fpFormatPkg::*;
	import addPipePkg::*;

	localparam int magWidth = expWidth + fracWidth;	// Word without sign

	fpClass_t              aClass;
	fpClass_t              bClass;
	logic                  bSign;		// b sign with op folded in
	logic [magWidth-1:0]   aMag;
	logic [magWidth-1:0]   bMag;
	logic                  aBig;
	logic [magWidth-1:0]   bigMag;
	logic [magWidth-1:0]   smallMag;
	logic [expWidth-1:0]   rawDiff;
	swapStage_t            swapNext;

	assign aClass = classify(a);
	assign bClass = classify(b);
	assign bSign  = b.fields.sign ^ op;	// Subtract is add of negated b

	// Flushed magnitudes, exponent over fraction compares as one integer
	assign aMag = aClass.isZero ? '0 : a.raw[magWidth-1:0];
	assign bMag = bClass.isZero ? '0 : b.raw[magWidth-1:0];
	assign aBig = aMag >= bMag;

	assign bigMag   = aBig ? aMag : bMag;
	assign smallMag = aBig ? bMag : aMag;
	assign rawDiff  = bigMag[magWidth-1:fracWidth] - smallMag[magWidth-1:fracWidth];

	always_comb begin
		swapNext.effSub = a.fields.sign ^ bSign;
		// Equal magnitudes: only two negatives keep a minus sign
		if (aMag == bMag)
			swapNext.sign = a.fields.sign & bSign;
		else
			swapNext.sign = aBig ? a.fields.sign : bSign;
		swapNext.bigExp   = bigMag[magWidth-1:fracWidth];
		swapNext.expDiff  = (rawDiff > 5'd15) ? 5'd15 : rawDiff;	// All bits go sticky past 14
		swapNext.bigSig   = {|bigMag[magWidth-1:fracWidth], bigMag[fracWidth-1:0]};
		swapNext.smallSig = {|smallMag[magWidth-1:fracWidth], smallMag[fracWidth-1:0]};

		swapNext.special = '0;
		if (aClass.isNaN || bClass.isNaN || (aClass.isInf && bClass.isInf && swapNext.effSub)) begin
			swapNext.special.isSpecial = 1'b1;
			swapNext.special.word      = qNaN;
			swapNext.special.invalid   = 1'b1;
		end else if (aClass.isInf) begin
			swapNext.special.isSpecial = 1'b1;
			swapNext.special.word      = a;
		end else if (bClass.isInf) begin
			swapNext.special.isSpecial = 1'b1;
			swapNext.special.word.raw  = {bSign, b.raw[magWidth-1:0]};	// Infinity, effective sign
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			swapOut <= '0;
		else
			swapOut <= swapNext;
	end

	// Invalid travels as a forced canonical NaN, never a computed word
	assert property (@(posedge clk) disable iff (rst)
		swapOut.special.invalid |-> swapOut.special.isSpecial && swapOut.special.word == qNaN);

endmodule

// File: logic/addPipePkg.sv
package addPipePkg;
	import fpFormatPkg::*;

	// Special-case outcome, decided in stage 1 and held to the output
	typedef struct packed {
		logic    isSpecial;	// NaN or infinity decides the result
		fp16Word word;		// Result word to force
		logic    invalid;
	} specialInfo_t;

	////////////////////////////////////////////////////////////
	// Stage 1 to stage 2
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                 effSub;	// Signs differ after op
		logic                 sign;		// Sign of the larger operand
		logic [expWidth-1:0]  bigExp;
		logic [expWidth-1:0]  expDiff;	// Saturated at 15
		logic [fracWidth:0]   bigSig;	// Hidden bit on top
		logic [fracWidth:0]   smallSig;
		specialInfo_t         special;
	} swapStage_t;

	////////////////////////////////////////////////////////////
	// Stage 2 to stage 3
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                 sign;
		logic [expWidth-1:0]  exponent;	// Exponent of the larger operand
		logic [fracWidth+4:0] sum;		// Carry, 11 bits, guard, round, sticky
		specialInfo_t         special;
	} sumStage_t;

	////////////////////////////////////////////////////////////
	// Stage 3 to stage 4
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                       sign;
		logic signed [expWidth+1:0] exponent;	// Goes negative on deep cancellation
		logic [fracWidth:0]         sig;		// Normalized, hidden bit on top
		logic                       guard;
		logic                       sticky;		// Round and sticky merged
		logic                       zero;		// Exact zero sum
		specialInfo_t               special;
	} normStage_t;

endpackage

// File: logic/fpFormatPkg.sv
package fpFormatPkg;

	////////////////////////////////////////////////////////////
	// binary16 layout
	////////////////////////////////////////////////////////////
	localparam int expWidth  = 5;	// Biased exponent field
	localparam int fracWidth = 10;	// Stored fraction, hidden bit not included
	localparam int expBias   = 15;

	typedef struct packed {
		logic                 sign;
		logic [expWidth-1:0]  exponent;
		logic [fracWidth-1:0] fraction;
	} fp16Fields;

	// Ports and testbench use raw bits, the stages use fields
	typedef union packed {
		logic [expWidth+fracWidth:0] raw;
		fp16Fields                   fields;
	} fp16Word;

	localparam fp16Word qNaN = 16'h7E00;	// Canonical quiet NaN

	////////////////////////////////////////////////////////////
	// Operand classes and result flags
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic isNaN;
		logic isInf;
		logic isZero;	// Zero or subnormal, both read as zero
	} fpClass_t;

	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} addFlags_t;

	// Exponent all ones splits NaN from infinity on the fraction
	function automatic fpClass_t classify(input fp16Word w);
		fpClass_t c;
		c.isNaN  = (&w.fields.exponent) && (|w.fields.fraction);
		c.isInf  = (&w.fields.exponent) && !(|w.fields.fraction);
		c.isZero = !(|w.fields.exponent);	// Subnormals flushed here
		return c;
	endfunction

endpackage
